// File: snes_pkg.sv
package snes_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////
  typedef logic [23:0] snes_addr_t;      // console / mcu byte address
  typedef logic [22:0] rom_word_addr_t;  // psram word address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [2:0]  mapper_t;
  typedef logic [4:0]  mem_delay_t;
  typedef logic [17:0] dead_cnt_t;

  // arbiter FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_END
  } arb_state_t;

  //////////////////////////////
  // timing
  //////////////////////////////
  localparam mem_delay_t ROM_CYCLE_LEN     = 5'd6;
  localparam dead_cnt_t  SNES_DEAD_TIMEOUT = 18'd80000;  // roughly 1 ms of CLK2

  // sampler depth and control lanes
  localparam int SYNC_DEPTH     = 7;
  localparam int NUM_CTRL_LINES = 4;
  localparam int CTRL_READ      = 0;
  localparam int CTRL_WRITE     = 1;
  localparam int CTRL_CPU_CLK   = 2;
  localparam int CTRL_ROMSEL    = 3;

  // mapper codes from the mcu
  localparam mapper_t MAPPER_HIROM = 3'd0;
  localparam mapper_t MAPPER_LOROM = 3'd1;

  localparam snes_addr_t SAVERAM_BASE = 24'hE00000;  // save ram sits at top of psram

endpackage

// File: snes_line_filter.sv
`timescale 1ns/1ps

module snes_line_filter import snes_pkg::*; (
  input  logic CLK2,
  input  logic rst,
  input  logic line_in,
  output logic level,
  output logic fall_strobe,
  output logic rise_strobe
);

  logic [SYNC_DEPTH-1:0] hist;  // [0] is the newest sample

  always_ff @(posedge CLK2) begin
    if (rst) begin
      hist <= '1;  // idle level of an active low strobe
    end else begin
      hist <= {hist[SYNC_DEPTH-2:0], line_in};
    end
  end

  // two-stage AND filters single-sample glitches
  assign level = hist[2] & hist[1];

  // edges only count after five stable samples
  assign fall_strobe = (hist[SYNC_DEPTH-1:1] == {{(SYNC_DEPTH-2){1'b1}}, 1'b0});
  assign rise_strobe = (hist[SYNC_DEPTH-1:1] == {{(SYNC_DEPTH-2){1'b0}}, 1'b1});

endmodule

// File: snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync import snes_pkg::*; (
  input  logic       CLK2,
  input  logic       rst,
  input  snes_addr_t snes_addr_in,
  input  logic       snes_read_in,
  input  logic       snes_write_in,
  input  logic       snes_cpu_clk_in,
  input  logic       snes_romsel_in,
  input  byte_t      snes_data_in,
  output snes_addr_t snes_addr,
  output byte_t      snes_data,
  output logic       snes_read,
  output logic       snes_write,
  output logic       snes_cpu_clk,
  output logic       snes_romsel,
  output logic       rd_start,
  output logic       rd_end,
  output logic       wr_end,
  output logic       cycle_start,
  output logic       cycle_end,
  output logic       cpu_clk_sample
);

  logic [NUM_CTRL_LINES-1:0] lane_in;
  logic [NUM_CTRL_LINES-1:0] lane_level;
  logic [NUM_CTRL_LINES-1:0] lane_fall;
  logic [NUM_CTRL_LINES-1:0] lane_rise;
  logic [1:0]                cpu_clk_hist;
  snes_addr_t                addr_hist [SYNC_DEPTH-1];
  byte_t                     data_hist [SYNC_DEPTH-1];

  //////////////////////////////
  // control lines
  //////////////////////////////
  assign lane_in[CTRL_READ]    = snes_read_in;
  assign lane_in[CTRL_WRITE]   = snes_write_in;
  assign lane_in[CTRL_CPU_CLK] = ~snes_cpu_clk_in;  // inverted so reset means clock low
  assign lane_in[CTRL_ROMSEL]  = snes_romsel_in;

  for (genvar i = 0; i < NUM_CTRL_LINES; i++) begin : g_line
    snes_line_filter line_filter_i (
      .CLK2        (CLK2),
      .rst         (rst),
      .line_in     (lane_in[i]),
      .level       (lane_level[i]),
      .fall_strobe (lane_fall[i]),
      .rise_strobe (lane_rise[i])
    );
  end

  assign snes_read    = lane_level[CTRL_READ];
  assign snes_write   = lane_level[CTRL_WRITE];
  assign snes_cpu_clk = ~lane_level[CTRL_CPU_CLK];
  assign snes_romsel  = lane_level[CTRL_ROMSEL];

  assign rd_start    = lane_fall[CTRL_READ];
  assign rd_end      = lane_rise[CTRL_READ];
  assign wr_end      = lane_rise[CTRL_WRITE];
  assign cycle_start = lane_fall[CTRL_CPU_CLK];  // inverted lane, so clock rising
  assign cycle_end   = lane_rise[CTRL_CPU_CLK];

  //////////////////////////////
  // address, data, raw clock
  //////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      cpu_clk_hist <= '0;
      for (int i = 0; i < SYNC_DEPTH-1; i++) begin
        addr_hist[i] <= '0;
        data_hist[i] <= '0;
      end
    end else begin
      cpu_clk_hist <= {cpu_clk_hist[0], snes_cpu_clk_in};
      addr_hist[0] <= snes_addr_in;
      data_hist[0] <= snes_data_in;
      for (int i = 1; i < SYNC_DEPTH-1; i++) begin
        addr_hist[i] <= addr_hist[i-1];
        data_hist[i] <= data_hist[i-1];
      end
    end
  end

  assign cpu_clk_sample = cpu_clk_hist[1];
  assign snes_addr      = addr_hist[5] & addr_hist[4];  // settled after 5 edges
  assign snes_data      = data_hist[5] & data_hist[4];

endmodule

// File: snes_alive_monitor.sv
`timescale 1ns/1ps

module snes_alive_monitor import snes_pkg::*; (
  input  logic CLK2,
  input  logic rst,
  input  logic cpu_clk_sample,
  output logic snes_dead
);

  dead_cnt_t dead_cnt;  // consecutive low samples

  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;  // assume no console until its clock shows up
    end else if (cpu_clk_sample) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      // saturate so a long power-off cannot wrap back under the limit
      if (dead_cnt != '1) begin
        dead_cnt <= dead_cnt + 1'b1;
      end
      if (dead_cnt > SNES_DEAD_TIMEOUT) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

// File: snes_addr_map.sv
`timescale 1ns/1ps

module snes_addr_map import snes_pkg::*; (
  input  snes_addr_t snes_addr,
  input  mapper_t    mapper,
  input  snes_addr_t rom_mask,
  input  snes_addr_t saveram_mask,
  output snes_addr_t mapped_addr,
  output logic       is_rom,
  output logic       is_saveram,
  output logic       rom_hit
);

  logic       rom_area;
  logic       sram_area;
  snes_addr_t rom_addr_map;
  snes_addr_t sram_addr_map;

  //////////////////////////////
  // mapper decode
  //////////////////////////////
  always_comb begin
    rom_area     = 1'b0;
    sram_area    = 1'b0;
    rom_addr_map = snes_addr & rom_mask;
    case (mapper)
      MAPPER_HIROM: begin
        rom_area     = snes_addr[22] | snes_addr[15];
        // banks 20-3f, 6000-7fff
        sram_area    = (snes_addr[23:21] == 3'b001) & (snes_addr[15:13] == 3'b011);
        rom_addr_map = {2'b00, snes_addr[21:0]} & rom_mask;
      end
      MAPPER_LOROM: begin
        rom_area     = snes_addr[15];
        sram_area    = (snes_addr[23:20] == 4'h7) & ~snes_addr[15];  // banks 70-7f, lower half
        rom_addr_map = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;  // drop a15
      end
      default: begin
        // unsupported mapper, nothing decodes
      end
    endcase
  end

  assign sram_addr_map = SAVERAM_BASE + (snes_addr & saveram_mask);

  assign is_saveram  = sram_area;
  assign is_rom      = rom_area & ~sram_area;
  assign rom_hit     = is_rom | is_saveram;
  assign mapped_addr = sram_area ? sram_addr_map : rom_addr_map;

endmodule

// File: rom_arbiter.sv
`timescale 1ns/1ps

module rom_arbiter import snes_pkg::*; (
  input  logic       CLK2,
  input  logic       rst,
  input  snes_addr_t mcu_addr,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  logic       cycle_start,
  input  logic       cycle_end,
  input  logic       rom_hit,
  input  logic       snes_dead,
  input  logic       snes_cpu_clk,
  input  rom_word_t  rom_data_in,
  output logic       mcu_rdy,
  output byte_t      mcu_din,
  output logic       mcu_access,
  output logic       mcu_write_phase,
  output snes_addr_t mcu_rom_addr
);

  arb_state_t state;
  mem_delay_t mem_delay;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;
  snes_addr_t req_addr;

  //////////////////////////////
  // free bus slots
  //////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;  // console cycle that leaves psram alone
    end
  end

  assign free_slot = cycle_end | free_strobe;

  //////////////////////////////
  // mcu request latch
  //////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rdy & mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_rdy & mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == ST_MCU_RD_END || state == ST_MCU_WR_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rdy & (mcu_rrq | mcu_wrq)) begin
      req_addr <= mcu_addr;
    end
  end

  //////////////////////////////
  // access FSM
  //////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      state     <= ST_IDLE;
      mem_delay <= '0;
    end else if (snes_dead & snes_cpu_clk) begin
      state <= ST_IDLE;  // console woke up, pending access reruns in a slot
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot | snes_dead) begin
            if (rd_pend) begin
              state     <= ST_MCU_RD_ADDR;
              mem_delay <= ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state     <= ST_MCU_WR_ADDR;
              mem_delay <= ROM_CYCLE_LEN;
            end
          end
        end
        ST_MCU_RD_ADDR, ST_MCU_WR_ADDR: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) begin
            state <= (state == ST_MCU_RD_ADDR) ? ST_MCU_RD_END : ST_MCU_WR_END;
          end
        end
        default: begin
          state <= ST_IDLE;  // end states last one cycle
        end
      endcase
    end
  end

  // last sample before the end state is the one the mcu sees
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD_ADDR) begin
      mcu_din <= req_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
    end
  end

  assign mcu_access      = (state == ST_MCU_RD_ADDR) | (state == ST_MCU_WR_ADDR);
  assign mcu_write_phase = (state == ST_MCU_WR_ADDR);
  assign mcu_rom_addr    = req_addr;

endmodule

// File: rom_bus_ctrl.sv
`timescale 1ns/1ps

module rom_bus_ctrl import snes_pkg::*; (
  input  snes_addr_t     mapped_addr,
  input  snes_addr_t     mcu_rom_addr,
  input  logic           mcu_access,
  input  logic           mcu_write_phase,
  input  byte_t          mcu_dout,
  input  logic           rom_hit,
  input  logic           is_rom,
  input  logic           is_saveram,
  input  logic           snes_read,
  input  logic           snes_write,
  input  logic           snes_cpu_clk,
  input  logic           snes_romsel,
  input  byte_t          snes_data,
  input  rom_word_t      rom_data_in,
  output rom_word_addr_t rom_addr,
  output rom_word_t      rom_data_out,
  output logic           rom_data_oe,
  output logic           rom_we,
  output logic           rom_bhe,
  output logic           rom_ble,
  output byte_t          snes_data_out,
  output logic           snes_data_oe,
  output logic           snes_databus_oe,
  output logic           snes_databus_dir
);

  snes_addr_t sel_addr;
  logic       lane_lo;
  logic       snes_wr_sel;
  logic       snes_wr_drive;
  logic       bus_sel;
  byte_t      wr_byte;

  //////////////////////////////
  // psram side
  //////////////////////////////
  assign sel_addr = mcu_access ? mcu_rom_addr : mapped_addr;
  assign lane_lo  = sel_addr[0];  // odd byte lives in the low lane
  assign rom_addr = sel_addr[23:1];
  assign rom_bhe  = lane_lo;
  assign rom_ble  = ~lane_lo;

  // console writes go straight through while its clock is high
  assign snes_wr_sel   = rom_hit & is_saveram & snes_cpu_clk;
  assign snes_wr_drive = snes_wr_sel & ~snes_write;

  assign rom_we = snes_wr_sel     ? snes_write :
                  mcu_write_phase ? 1'b0 :
                                    1'b1;

  assign wr_byte      = snes_wr_drive ? snes_data : mcu_dout;
  assign rom_data_out = {wr_byte, wr_byte};  // unused lane masked by bhe/ble
  assign rom_data_oe  = snes_wr_drive | mcu_write_phase;

  //////////////////////////////
  // console side
  //////////////////////////////
  assign bus_sel = (is_rom & ~snes_romsel) | is_saveram;

  assign snes_data_out    = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_oe     = bus_sel & ~snes_read;
  assign snes_databus_oe  = ~(bus_sel & (~snes_read | ~snes_write));  // active low
  assign snes_databus_dir = ~snes_read;  // 1 = toward console

endmodule

// File: sd2snes_main.sv
`timescale 1ns/1ps

module sd2snes_main import snes_pkg::*; (
  input  logic           CLK2,
  input  logic           rst,
  // console bus
  input  snes_addr_t     snes_addr_in,
  input  logic           snes_read_in,
  input  logic           snes_write_in,
  input  logic           snes_cpu_clk_in,
  input  logic           snes_romsel_in,
  input  byte_t          snes_data_in,
  output byte_t          snes_data_out,
  output logic           snes_data_oe,
  output logic           snes_databus_oe,
  output logic           snes_databus_dir,
  // psram
  output rom_word_addr_t rom_addr,
  output rom_word_t      rom_data_out,
  output logic           rom_data_oe,
  output logic           rom_we,
  output logic           rom_bhe,
  output logic           rom_ble,
  input  rom_word_t      rom_data_in,
  // mcu
  input  snes_addr_t     mcu_addr,
  input  byte_t          mcu_dout,
  input  logic           mcu_rrq,
  input  logic           mcu_wrq,
  input  mapper_t        mapper,
  input  snes_addr_t     rom_mask,
  input  snes_addr_t     saveram_mask,
  output byte_t          mcu_din,
  output logic           mcu_rdy
);

  snes_addr_t snes_addr;
  byte_t      snes_data;
  logic       snes_read;
  logic       snes_write;
  logic       snes_cpu_clk;
  logic       snes_romsel;
  logic       cycle_start;
  logic       cycle_end;
  logic       cpu_clk_sample;
  logic       snes_dead;
  snes_addr_t mapped_addr;
  logic       is_rom;
  logic       is_saveram;
  logic       rom_hit;
  logic       mcu_access;
  logic       mcu_write_phase;
  snes_addr_t mcu_rom_addr;

  // register strobes have no consumer in this core
  snes_bus_sync bus_sync_i (
    .*,
    .rd_start (),
    .rd_end   (),
    .wr_end   ()
  );

  snes_alive_monitor alive_monitor_i (.*);

  snes_addr_map addr_map_i (.*);

  rom_arbiter rom_arbiter_i (.*);

  rom_bus_ctrl rom_bus_ctrl_i (.*);

endmodule

// File: sd2snes_main_sva.sv
`timescale 1ns/1ps

module sd2snes_main_sva import snes_pkg::*; (
  input logic      CLK2,
  input logic      rst,
  input logic      mcu_rrq,
  input logic      mcu_wrq,
  input logic      mcu_rdy,
  input logic      rom_we,
  input logic      rom_data_oe,
  input rom_word_t rom_data_out,
  input byte_t     mcu_dout,
  input logic      mcu_write_phase,
  input logic      snes_data_oe,
  input logic      snes_databus_oe
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  // quiet buses straight out of reset
  reset_idle: assert property (@(posedge CLK2)
    rst |=> mcu_rdy && rom_we && snes_databus_oe && !snes_data_oe && !rom_data_oe)
    else begin
      fail_cnt++;
      $error("bus not idle after reset");
    end

  req_accept: assert property (@(posedge CLK2) disable iff (rst)
    mcu_rdy && (mcu_rrq || mcu_wrq) |=> !mcu_rdy)
    else begin
      fail_cnt++;
      $error("mcu_rdy did not drop after a request");
    end

  // mcu write phase owns the psram bus
  write_owner: assert property (@(posedge CLK2) disable iff (rst)
    mcu_write_phase |-> !rom_we && rom_data_oe && rom_data_out == {mcu_dout, mcu_dout})
    else begin
      fail_cnt++;
      $error("psram not driven by mcu during write phase");
    end

endmodule

bind sd2snes_main sd2snes_main_sva sva_i (
  .CLK2             (CLK2),
  .rst              (rst),
  .mcu_rrq          (mcu_rrq),
  .mcu_wrq          (mcu_wrq),
  .mcu_rdy          (mcu_rdy),
  .rom_we           (rom_we),
  .rom_data_oe      (rom_data_oe),
  .rom_data_out     (rom_data_out),
  .mcu_dout         (mcu_dout),
  .mcu_write_phase  (mcu_write_phase),
  .snes_data_oe     (snes_data_oe),
  .snes_databus_oe  (snes_databus_oe)
);

// File: tb_sd2snes_main.sv
`timescale 1ns/1ps

module tb_sd2snes_main import snes_pkg::*; ();

  localparam int WATCHDOG_CYCLES = 2 * SNES_DEAD_TIMEOUT + 40000;  // two dead timeouts plus accesses
  localparam int ACCESS_LIMIT    = ROM_CYCLE_LEN + 4;

  logic           CLK2;
  logic           rst;
  snes_addr_t     snes_addr_in;
  logic           snes_read_in;
  logic           snes_write_in;
  logic           snes_cpu_clk_in;
  logic           snes_romsel_in;
  byte_t          snes_data_in;
  byte_t          snes_data_out;
  logic           snes_data_oe;
  logic           snes_databus_oe;
  logic           snes_databus_dir;
  rom_word_addr_t rom_addr;
  rom_word_t      rom_data_out;
  logic           rom_data_oe;
  logic           rom_we;
  logic           rom_bhe;
  logic           rom_ble;
  rom_word_t      rom_data_in;
  snes_addr_t     mcu_addr;
  byte_t          mcu_dout;
  logic           mcu_rrq;
  logic           mcu_wrq;
  mapper_t        mapper;
  snes_addr_t     rom_mask;
  snes_addr_t     saveram_mask;
  byte_t          mcu_din;
  logic           mcu_rdy;

  rom_word_t   mem [rom_word_addr_t];  // psram words written so far
  rom_word_t   store_word;
  int          errors;
  int unsigned seed_val;

  sd2snes_main dut_i (.*);

  initial CLK2 = 1'b0;
  always #4 CLK2 = ~CLK2;

  //////////////////////////////
  // psram model
  //////////////////////////////
  function automatic rom_word_t fill_word(rom_word_addr_t a);
    return {a[22:15] ^ a[7:0], a[14:7] ^ 8'hc3};  // every address bit shows up
  endfunction

  function automatic rom_word_t word_at(rom_word_addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  function automatic byte_t byte_at(snes_addr_t a);
    rom_word_t w;
    w = word_at(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];  // odd byte in the low lane
  endfunction

  always_comb rom_data_in = word_at(rom_addr);

  always @(negedge CLK2) begin
    if (!rst && rom_we === 1'b0 && rom_data_oe === 1'b1) begin
      store_word = word_at(rom_addr);
      if (!rom_bhe) begin
        store_word[15:8] = rom_data_out[15:8];
      end
      if (!rom_ble) begin
        store_word[7:0] = rom_data_out[7:0];
      end
      mem[rom_addr] = store_word;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic advance();
    @(posedge CLK2);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    value_ok: assert (actual === expected) else begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // one-cycle request pulse, rdy must drop right after
  task automatic issue_request(input logic write, input snes_addr_t addr, input byte_t data);
    mcu_addr = addr;
    mcu_dout = data;
    mcu_wrq  = write;
    mcu_rrq  = !write;
    advance();
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    check_val("mcu_rdy", 0, 32'(mcu_rdy));
  endtask

  task automatic wait_ready(input int limit, input snes_addr_t addr, input byte_t data,
                            output int we_low);
    int cycles;
    cycles = 0;
    we_low = 0;
    while (mcu_rdy !== 1'b1 && cycles < limit) begin
      @(negedge CLK2);
      if (rom_we === 1'b0) begin
        we_low++;
        check_val("rom_addr", 32'(addr[23:1]), 32'(rom_addr));
        check_val("rom_bhe", 32'(addr[0]), 32'(rom_bhe));
        check_val("rom_ble", 32'(!addr[0]), 32'(rom_ble));
        check_val("rom_data_out", 32'({data, data}), 32'(rom_data_out));
      end
      advance();
      cycles++;
    end
    if (mcu_rdy !== 1'b1) begin
      errors++;
      $display("mcu access at %0t did not finish within %0d cycles", $time, limit);
    end
  endtask

  task automatic mcu_write(input snes_addr_t addr, input byte_t data);
    int we_low;
    issue_request(1'b1, addr, data);
    wait_ready(ACCESS_LIMIT, addr, data, we_low);
    check_val("rom_we low cycles", ROM_CYCLE_LEN + 1, we_low);
    check_val("psram byte", 32'(data), 32'(byte_at(addr)));
  endtask

  task automatic mcu_read(input snes_addr_t addr);
    int we_low;
    issue_request(1'b0, addr, 8'h00);
    wait_ready(ACCESS_LIMIT, addr, 8'h00, we_low);
    check_val("rom_we low cycles", 0, we_low);
    check_val("mcu_din", 32'(byte_at(addr)), 32'(mcu_din));
  endtask

  task automatic console_read(input snes_addr_t addr, input snes_addr_t mapped);
    snes_addr_in   = addr;
    snes_romsel_in = 1'b0;
    snes_read_in   = 1'b0;
    repeat (6) @(posedge CLK2);  // address history settles after 5 edges
    @(negedge CLK2);
    check_val("rom_addr", 32'(mapped[23:1]), 32'(rom_addr));
    check_val("snes_databus_oe", 0, 32'(snes_databus_oe));
    check_val("snes_databus_dir", 1, 32'(snes_databus_dir));
    check_val("snes_data_oe", 1, 32'(snes_data_oe));
    check_val("snes_data_out", 32'(byte_at(mapped)), 32'(snes_data_out));
    advance();
    snes_read_in   = 1'b1;
    snes_romsel_in = 1'b1;
    repeat (4) advance();
  endtask

  task automatic console_write(input snes_addr_t addr, input byte_t data);
    snes_addr_t mapped;
    mapped          = SAVERAM_BASE + (addr & saveram_mask);
    snes_addr_in    = addr;
    snes_data_in    = data;
    snes_cpu_clk_in = 1'b1;  // console comes alive here
    repeat (6) advance();
    snes_write_in = 1'b0;
    repeat (3) advance();
    @(negedge CLK2);
    check_val("rom_we", 0, 32'(rom_we));
    check_val("rom_addr", 32'(mapped[23:1]), 32'(rom_addr));
    advance();
    snes_write_in = 1'b1;
    repeat (3) advance();
    @(negedge CLK2);
    check_val("rom_we", 1, 32'(rom_we));
    check_val("saveram byte", 32'(data), 32'(byte_at(mapped)));
    advance();
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    logic [31:0] rnd;
    snes_addr_t  addr;
    int          we_low;
    seed_val        = $urandom(32'hb16f);
    errors          = 0;
    rst             = 1'b1;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_cpu_clk_in = 1'b0;
    snes_romsel_in  = 1'b1;
    snes_data_in    = '0;
    mcu_addr        = '0;
    mcu_dout        = '0;
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mapper          = MAPPER_HIROM;
    rom_mask        = 24'h3FFFFF;
    saveram_mask    = 24'h001FFF;
    repeat (2) @(posedge CLK2);
    #1;
    rst = 1'b0;

    @(negedge CLK2);
    check_val("mcu_rdy", 1, 32'(mcu_rdy));
    check_val("rom_we", 1, 32'(rom_we));
    check_val("snes_databus_oe", 1, 32'(snes_databus_oe));
    check_val("snes_data_oe", 0, 32'(snes_data_oe));
    check_val("rom_data_oe", 0, 32'(rom_data_oe));
    advance();

    // console dead from reset, accesses run at once
    rnd = $urandom();
    mcu_write(rnd[23:0], rnd[31:24]);
    mcu_read(rnd[23:0]);
    rnd = $urandom();
    mcu_read(rnd[23:0]);

    rnd  = $urandom();
    addr = {2'b11, rnd[21:0]};
    console_read(addr, {2'b00, addr[21:0]} & rom_mask);
    mapper = MAPPER_LOROM;
    rnd    = $urandom();
    addr   = {1'b0, rnd[22:16], 1'b1, rnd[14:0]};
    console_read(addr, {2'b00, addr[22:16], addr[14:0]} & rom_mask);
    mapper = MAPPER_HIROM;

    rnd = $urandom();
    console_write({3'b001, rnd[20:16], 3'b011, rnd[12:0]}, rnd[31:24]);

    // clock held high, no slot until it falls
    rnd  = $urandom();
    addr = rnd[23:0];
    issue_request(1'b0, addr, 8'h00);
    repeat (20) begin
      @(negedge CLK2);
      check_val("mcu_rdy", 0, 32'(mcu_rdy));
      advance();
    end
    snes_cpu_clk_in = 1'b0;
    wait_ready(ACCESS_LIMIT + 4, addr, 8'h00, we_low);
    check_val("rom_we low cycles", 0, we_low);
    check_val("mcu_din", 32'(byte_at(addr)), 32'(mcu_din));

    repeat (SNES_DEAD_TIMEOUT + 16) advance();  // let the console go dead again
    rnd = $urandom();
    mcu_write(rnd[23:0], rnd[31:24]);
    mcu_read(rnd[23:0]);

    repeat (4) advance();
    $display("done: %0d testbench errors, %0d assertion failures",
             errors, dut_i.sva_i.fail_cnt);
    if (errors == 0 && dut_i.sva_i.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: sd2snes_main.f
snes_pkg.sv
snes_line_filter.sv
snes_bus_sync.sv
snes_alive_monitor.sv
snes_addr_map.sv
rom_arbiter.sv
rom_bus_ctrl.sv
sd2snes_main.sv
sd2snes_main_sva.sv
tb_sd2snes_main.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_sd2snes_main
RTL_TOP   := sd2snes_main
FILELIST  := sd2snes_main.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
